// File: source/stm_pkg.sv
package stm_pkg;

  // segment switching modes, one byte on the bus
  typedef enum logic [7:0] {
    transition_mode_sync_idx = 8'd0,
    transition_mode_sys_time = 8'd1,
    transition_mode_gpio     = 8'd2
  } transition_mode_t;

  localparam int num_segments   = 2;
  localparam int sync_idx_width = 16;
  localparam int rep_width      = 32;
  localparam int sys_time_width = 64;

  // all ones keeps the segment looping forever
  localparam logic [rep_width-1:0] rep_infinite = '1;

  localparam int axil_addr_width = 8;
  localparam int axil_data_width = 32;

  // ----------------------------------------------------------
  // register map
  // ----------------------------------------------------------
  localparam logic [axil_addr_width-1:0] reg_ctrl     = 8'h00;
  localparam logic [axil_addr_width-1:0] reg_mode     = 8'h04;
  localparam logic [axil_addr_width-1:0] reg_value_lo = 8'h08;
  localparam logic [axil_addr_width-1:0] reg_value_hi = 8'h0C;
  localparam logic [axil_addr_width-1:0] reg_cycle0   = 8'h10;
  localparam logic [axil_addr_width-1:0] reg_cycle1   = 8'h14;
  localparam logic [axil_addr_width-1:0] reg_rep0     = 8'h18;
  localparam logic [axil_addr_width-1:0] reg_rep1     = 8'h1C;
  localparam logic [axil_addr_width-1:0] reg_status   = 8'h20;
  localparam logic [axil_addr_width-1:0] reg_idx0     = 8'h24;
  localparam logic [axil_addr_width-1:0] reg_idx1     = 8'h28;

  // bit positions in ctrl and status
  localparam int ctrl_update_bit     = 0;
  localparam int ctrl_segment_bit    = 1;
  localparam int status_segment_bit  = 0;
  localparam int status_stop_bit     = 1;
  localparam int status_miss_bit     = 2;

endpackage

// File: source/stm_settings_if.sv
`timescale 1ns/1ps

interface stm_settings_if;
  import stm_pkg::*;

  logic                      update;
  logic                      req_segment;
  transition_mode_t          mode;
  logic [sys_time_width-1:0] value;
  logic [sync_idx_width-1:0] cycle [num_segments];
  logic [rep_width-1:0]      rep [num_segments];

  modport regs (
    output update, req_segment, mode, value, cycle, rep
  );

  // the time base only needs the wrap points
  modport timebase (
    input cycle
  );

  modport swapchain (
    input update, req_segment, mode, value, cycle, rep
  );

endinterface

// File: source/stm_axil_regs.sv
`timescale 1ns/1ps

module stm_axil_regs (
  input  logic                                   CLK,
  input  logic                                   reset,
  input  logic [stm_pkg::axil_addr_width-1:0]    awaddr,
  input  logic                                   awvalid,
  output logic                                   awready,
  input  logic [stm_pkg::axil_data_width-1:0]    wdata,
  input  logic [stm_pkg::axil_data_width/8-1:0]  wstrb,
  input  logic                                   wvalid,
  output logic                                   wready,
  output logic [1:0]                             bresp,
  output logic                                   bvalid,
  input  logic                                   bready,
  input  logic [stm_pkg::axil_addr_width-1:0]    araddr,
  input  logic                                   arvalid,
  output logic                                   arready,
  output logic [stm_pkg::axil_data_width-1:0]    rdata,
  output logic [1:0]                             rresp,
  output logic                                   rvalid,
  input  logic                                   rready,
  stm_settings_if.regs                           settings,
  input  logic                                   stop,
  input  logic                                   segment,
  input  logic [stm_pkg::sync_idx_width-1:0]     idx [stm_pkg::num_segments],
  input  logic                                   err_miss
);
  import stm_pkg::*;

  localparam int strb_width = axil_data_width / 8;

  logic                       wr_start;
  logic                       wr_fire;
  logic                       rd_start;
  logic                       rd_fire;
  logic [axil_data_width-1:0] wr_old;
  logic [axil_data_width-1:0] wr_merged;

  // current content of a register as seen on the read channel
  function automatic logic [axil_data_width-1:0] reg_value(
    input logic [axil_addr_width-1:0] addr
  );
    logic [axil_data_width-1:0] v;
    v = '0;
    case (addr)
      reg_ctrl:     v[ctrl_segment_bit] = settings.req_segment;
      reg_mode:     v[7:0] = settings.mode;
      reg_value_lo: v = settings.value[31:0];
      reg_value_hi: v = settings.value[63:32];
      reg_cycle0:   v[sync_idx_width-1:0] = settings.cycle[0];
      reg_cycle1:   v[sync_idx_width-1:0] = settings.cycle[1];
      reg_rep0:     v = settings.rep[0];
      reg_rep1:     v = settings.rep[1];
      reg_status: begin
        v[status_segment_bit] = segment;
        v[status_stop_bit]    = stop;
        v[status_miss_bit]    = err_miss;
      end
      reg_idx0:     v[sync_idx_width-1:0] = idx[0];
      reg_idx1:     v[sync_idx_width-1:0] = idx[1];
      default:      v = '0;
    endcase
    return v;
  endfunction

  function automatic logic [axil_data_width-1:0] apply_strb(
    input logic [axil_data_width-1:0] old_v,
    input logic [axil_data_width-1:0] new_v,
    input logic [strb_width-1:0]      strb
  );
    logic [axil_data_width-1:0] res;
    res = old_v;
    for (int i = 0; i < strb_width; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_v[8*i +: 8];
      end
    end
    return res;
  endfunction

  // ----------------------------------------------------------
  // handshakes
  // ----------------------------------------------------------
  // no new write while a response is still pending
  assign wr_start = awvalid && wvalid && !awready && !bvalid;
  assign wr_fire  = awvalid && awready;
  assign rd_start = arvalid && !arready && !rvalid;
  assign rd_fire  = arvalid && arready;

  assign bresp = 2'b00;
  assign rresp = 2'b00;

  always_comb begin
    wr_old    = reg_value(awaddr);
    wr_merged = apply_strb(wr_old, wdata, wstrb);
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      awready              <= 1'b0;
      wready               <= 1'b0;
      bvalid               <= 1'b0;
      arready              <= 1'b0;
      rvalid               <= 1'b0;
      settings.update      <= 1'b0;
      settings.req_segment <= 1'b0;
      settings.mode        <= transition_mode_sync_idx;
      settings.value       <= '0;
      settings.cycle       <= '{default: '0};
      settings.rep         <= '{default: '0};
    end else begin
      awready <= wr_start;
      wready  <= wr_start;
      arready <= rd_start;

      // update fires after the other fields have settled
      settings.update <= wr_fire && (awaddr == reg_ctrl) &&
                         wstrb[0] && wdata[ctrl_update_bit];

      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end

      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end

      if (wr_fire) begin
        case (awaddr)
          reg_ctrl:     settings.req_segment <= wr_merged[ctrl_segment_bit];
          reg_mode:     settings.mode <= transition_mode_t'(wr_merged[7:0]);
          reg_value_lo: settings.value[31:0] <= wr_merged;
          reg_value_hi: settings.value[63:32] <= wr_merged;
          reg_cycle0:   settings.cycle[0] <= wr_merged[sync_idx_width-1:0];
          reg_cycle1:   settings.cycle[1] <= wr_merged[sync_idx_width-1:0];
          reg_rep0:     settings.rep[0] <= wr_merged;
          reg_rep1:     settings.rep[1] <= wr_merged;
          default: begin
          end
        endcase
      end
    end
  end

  // read data is sampled at the address handshake
  always_ff @(posedge CLK) begin
    if (rd_fire) begin
      rdata <= reg_value(araddr);
    end
  end

endmodule

// File: source/stm_timebase.sv
`timescale 1ns/1ps

module stm_timebase #(
  parameter int unsigned tick_div = 4
) (
  input  logic                               CLK,
  input  logic                               reset,
  stm_settings_if.timebase                   settings,
  output logic [stm_pkg::sys_time_width-1:0] sys_time,
  output logic [stm_pkg::sync_idx_width-1:0] sync_idx [stm_pkg::num_segments]
);
  import stm_pkg::*;

  localparam int presc_width = (tick_div > 1) ? $clog2(tick_div) : 1;
  localparam logic [presc_width-1:0] presc_last = presc_width'(tick_div - 1);

  logic [presc_width-1:0] presc;
  logic                   tick;

  // free running system time
  always_ff @(posedge CLK) begin
    if (reset) begin
      sys_time <= '0;
    end else begin
      sys_time <= sys_time + 1'b1;
    end
  end

  // ----------------------------------------------------------
  // prescaler
  // ----------------------------------------------------------
  assign tick = (presc == presc_last);

  always_ff @(posedge CLK) begin
    if (reset) begin
      presc <= '0;
    end else if (tick) begin
      presc <= '0;
    end else begin
      presc <= presc + 1'b1;
    end
  end

  // ----------------------------------------------------------
  // sync index per segment
  // ----------------------------------------------------------
  for (genvar s = 0; s < num_segments; s++) begin : g_seg
    always_ff @(posedge CLK) begin
      if (reset) begin
        sync_idx[s] <= '0;
      end else if (tick) begin
        // >= also recovers when the cycle is lowered under the index
        if (sync_idx[s] >= settings.cycle[s]) begin
          sync_idx[s] <= '0;
        end else begin
          sync_idx[s] <= sync_idx[s] + 1'b1;
        end
      end
    end
  end

endmodule

// File: source/stm_swapchain.sv
`timescale 1ns/1ps

module stm_swapchain (
  input  logic                               CLK,
  input  logic                               reset,
  stm_settings_if.swapchain                  settings,
  input  logic [stm_pkg::sys_time_width-1:0] sys_time,
  input  logic [stm_pkg::sync_idx_width-1:0] sync_idx [stm_pkg::num_segments],
  input  logic [3:0]                         gpio_in,
  output logic                               stop,
  output logic                               segment,
  output logic [stm_pkg::sync_idx_width-1:0] idx [stm_pkg::num_segments],
  output logic                               err_miss
);
  import stm_pkg::*;

  typedef enum logic [1:0] {
    wait_start,
    finite_loop,
    infinite_loop
  } state_t;

  typedef enum logic {
    idx_mode_sync_idx,
    idx_mode_tic
  } idx_mode_t;

  state_t                    state;
  idx_mode_t                 idx_mode;
  logic                      req_segment;
  transition_mode_t          transition_mode;
  logic [sys_time_width-1:0] transition_value;
  logic [rep_width-1:0]      rep;
  logic [rep_width-1:0]      loop_cnt;
  logic [sync_idx_width-1:0] idx_old [num_segments];
  logic [sync_idx_width-1:0] tic_idx [num_segments];
  logic                      idx_changed [num_segments];
  logic                      target_wrap;
  logic                      cur_wrap;
  logic                      time_reached;
  logic                      time_missed;

  always_comb begin
    for (int s = 0; s < num_segments; s++) begin
      idx_changed[s] = (idx_old[s] != sync_idx[s]);
      idx[s] = (idx_mode == idx_mode_tic) ? tic_idx[s] : idx_old[s];
    end
  end

  assign target_wrap  = idx_changed[req_segment] && (sync_idx[req_segment] == '0);
  assign cur_wrap     = idx_changed[segment] && (sync_idx[segment] == '0);
  assign time_reached = (sys_time >= transition_value);
  // checked against the incoming request, not the armed value
  assign time_missed  = (settings.value < sys_time);

  always_ff @(posedge CLK) begin
    if (reset) begin
      idx_old <= '{default: '0};
    end else begin
      idx_old <= sync_idx;
    end
  end

  // ----------------------------------------------------------
  // transition FSM
  // ----------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (reset) begin
      state    <= infinite_loop;
      idx_mode <= idx_mode_sync_idx;
      stop     <= 1'b0;
      err_miss <= 1'b0;
      segment  <= 1'b0;
      loop_cnt <= '0;
      tic_idx  <= '{default: '0};
    end else if (settings.update) begin
      if (settings.req_segment == segment) begin
        stop     <= 1'b0;
        err_miss <= 1'b0;
        idx_mode <= idx_mode_sync_idx;
        state    <= infinite_loop;
      end else if (settings.rep[settings.req_segment] == rep_infinite) begin
        stop     <= 1'b0;
        err_miss <= 1'b0;
        segment  <= settings.req_segment;
        idx_mode <= idx_mode_sync_idx;
        state    <= infinite_loop;
      end else if ((settings.mode == transition_mode_sys_time) && time_missed) begin
        err_miss <= 1'b1;
        state    <= infinite_loop;
      end else begin
        err_miss         <= 1'b0;
        rep              <= settings.rep[settings.req_segment];
        transition_mode  <= settings.mode;
        transition_value <= settings.value;
        req_segment      <= settings.req_segment;
        state            <= wait_start;
      end
    end else begin
      case (state)
        wait_start: begin
          case (transition_mode)
            transition_mode_sync_idx: begin
              if (target_wrap) begin
                stop     <= 1'b0;
                loop_cnt <= '0;
                segment  <= req_segment;
                idx_mode <= idx_mode_sync_idx;
                state    <= finite_loop;
              end
            end
            transition_mode_sys_time: begin
              if (time_reached) begin
                stop     <= 1'b0;
                loop_cnt <= '0;
                segment  <= req_segment;
                idx_mode <= idx_mode_sync_idx;
                state    <= finite_loop;
              end
            end
            transition_mode_gpio: begin
              if (idx_changed[req_segment] && gpio_in[transition_value[1:0]]) begin
                stop                 <= 1'b0;
                loop_cnt             <= '0;
                segment              <= req_segment;
                idx_mode             <= idx_mode_tic;
                tic_idx[req_segment] <= '0;
                state                <= finite_loop;
              end
            end
            default: begin
              // unknown mode waits for the next request
              state <= wait_start;
            end
          endcase
        end
        finite_loop: begin
          if (idx_mode == idx_mode_sync_idx) begin
            if (cur_wrap) begin
              if (loop_cnt == rep) begin
                stop <= 1'b1;
              end else begin
                loop_cnt <= loop_cnt + 1'b1;
              end
            end
          end else if (idx_changed[segment]) begin
            // tic mode counts its own index against the cycle
            if (tic_idx[segment] >= settings.cycle[segment]) begin
              tic_idx[segment] <= '0;
              if (loop_cnt == rep) begin
                stop <= 1'b1;
              end else begin
                loop_cnt <= loop_cnt + 1'b1;
              end
            end else begin
              tic_idx[segment] <= tic_idx[segment] + 1'b1;
            end
          end
        end
        infinite_loop: begin
          state <= infinite_loop;
        end
        default: begin
          state <= infinite_loop;
        end
      endcase
    end
  end

endmodule

// File: source/stm_top.sv
`timescale 1ns/1ps

module stm_top #(
  parameter int unsigned tick_div = 4
) (
  input  logic                                   CLK,
  input  logic                                   reset,
  input  logic [stm_pkg::axil_addr_width-1:0]    awaddr,
  input  logic                                   awvalid,
  output logic                                   awready,
  input  logic [stm_pkg::axil_data_width-1:0]    wdata,
  input  logic [stm_pkg::axil_data_width/8-1:0]  wstrb,
  input  logic                                   wvalid,
  output logic                                   wready,
  output logic [1:0]                             bresp,
  output logic                                   bvalid,
  input  logic                                   bready,
  input  logic [stm_pkg::axil_addr_width-1:0]    araddr,
  input  logic                                   arvalid,
  output logic                                   arready,
  output logic [stm_pkg::axil_data_width-1:0]    rdata,
  output logic [1:0]                             rresp,
  output logic                                   rvalid,
  input  logic                                   rready,
  input  logic [3:0]                             gpio_in,
  output logic                                   stop,
  output logic                                   segment,
  output logic [stm_pkg::sync_idx_width-1:0]     idx0,
  output logic [stm_pkg::sync_idx_width-1:0]     idx1,
  output logic                                   err_miss
);
  import stm_pkg::*;

  logic [sys_time_width-1:0] sys_time;
  logic [sync_idx_width-1:0] sync_idx [num_segments];
  logic [sync_idx_width-1:0] idx [num_segments];

  stm_settings_if settings ();

  stm_axil_regs u_regs (
    .CLK      (CLK),
    .reset    (reset),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .settings (settings),
    .stop     (stop),
    .segment  (segment),
    .idx      (idx),
    .err_miss (err_miss)
  );

  stm_timebase #(
    .tick_div (tick_div)
  ) u_timebase (
    .CLK      (CLK),
    .reset    (reset),
    .settings (settings),
    .sys_time (sys_time),
    .sync_idx (sync_idx)
  );

  stm_swapchain u_swapchain (
    .CLK      (CLK),
    .reset    (reset),
    .settings (settings),
    .sys_time (sys_time),
    .sync_idx (sync_idx),
    .gpio_in  (gpio_in),
    .stop     (stop),
    .segment  (segment),
    .idx      (idx),
    .err_miss (err_miss)
  );

  assign idx0 = idx[0];
  assign idx1 = idx[1];

endmodule

// File: tests/stm_props.sv
`timescale 1ns/1ps

module stm_props (
  input logic                               CLK,
  input logic                               reset,
  input logic                               bvalid,
  input logic                               bready,
  input logic                               rvalid,
  input logic                               rready,
  input logic                               err_miss,
  input logic                               segment,
  input logic [stm_pkg::sync_idx_width-1:0] idx0,
  input logic [stm_pkg::sync_idx_width-1:0] idx1,
  input logic [stm_pkg::sync_idx_width-1:0] cycle0,
  input logic [stm_pkg::sync_idx_width-1:0] cycle1
);

  // responses stay up until taken
  assert property (@(posedge CLK) disable iff (reset) bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready was high");

  assert property (@(posedge CLK) disable iff (reset) rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready was high");

  // a missed time target never moves the segment
  assert property (@(posedge CLK) disable iff (reset) err_miss |-> $stable(segment))
    else $error("segment changed while err_miss was set");

  assert property (@(posedge CLK) disable iff (reset) idx0 <= cycle0)
    else $error("idx0 went past its programmed cycle");

  assert property (@(posedge CLK) disable iff (reset) idx1 <= cycle1)
    else $error("idx1 went past its programmed cycle");

endmodule

bind stm_top stm_props u_props (
  .CLK      (CLK),
  .reset    (reset),
  .bvalid   (bvalid),
  .bready   (bready),
  .rvalid   (rvalid),
  .rready   (rready),
  .err_miss (err_miss),
  .segment  (segment),
  .idx0     (idx0),
  .idx1     (idx1),
  .cycle0   (settings.cycle[0]),
  .cycle1   (settings.cycle[1])
);

// File: tests/tb_stm_top.sv
`timescale 1ns/1ps

module tb_stm_top;
  import stm_pkg::*;

  localparam int tick_div     = 2;
  localparam int num_rows     = 8;
  localparam int poll_limit   = 150;
  localparam int steady_polls = 10;
  localparam int max_cycle    = 8;
  // clocks for one full index loop at the longest cycle
  localparam int loop_clks    = (max_cycle + 1) * tick_div;
  localparam longint watchdog_ns = longint'(num_rows) * poll_limit * loop_clks * 10;

  typedef struct {
    logic [7:0]  mode;
    logic        req_seg;
    logic [31:0] rep0;
    logic [31:0] rep1;
    logic [15:0] cycle0;
    logic [15:0] cycle1;
    longint      value;
    bit          rel;
    logic [3:0]  gpio;
    bit          steady;
    logic [2:0]  exp_status;
  } row_t;

  logic        CLK;
  logic        reset;
  logic [7:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [7:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic [3:0]  gpio_in;
  logic        stop;
  logic        segment;
  logic [15:0] idx0;
  logic [15:0] idx1;
  logic        err_miss;

  row_t        rows [num_rows];
  logic [15:0] cyc0;
  logic [15:0] cyc1;
  logic [63:0] tb_time;
  int          errors;

  // switch monitor state
  logic        mon_seg;
  logic [15:0] prev_idx;
  logic        prev_stop;
  int          wrap_cnt;
  int          wraps_at_stop;
  logic [15:0] idx_at_switch;
  logic [15:0] max_idx;

  stm_top #(
    .tick_div (tick_div)
  ) u_dut (
    .CLK (CLK), .reset (reset),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
    .bresp (bresp), .bvalid (bvalid), .bready (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
    .gpio_in (gpio_in), .stop (stop), .segment (segment),
    .idx0 (idx0), .idx1 (idx1), .err_miss (err_miss)
  );

  initial CLK = 1'b0;
  always #5 CLK = ~CLK;

  // system time as the time base counts it
  always @(posedge CLK) begin
    if (reset) begin
      tb_time <= '0;
    end else begin
      tb_time <= tb_time + 1;
    end
  end

  // ----------------------------------------------------------
  // wraps of the active segment since its last switch
  // ----------------------------------------------------------
  always @(negedge CLK) begin
    logic [15:0] cur_idx;
    cur_idx = segment ? idx1 : idx0;
    if (reset) begin
      mon_seg       = 1'b0;
      prev_idx      = '0;
      prev_stop     = 1'b0;
      wrap_cnt      = 0;
      wraps_at_stop = -1;
      idx_at_switch = '0;
      max_idx       = '0;
    end else begin
      if (segment != mon_seg) begin
        mon_seg       = segment;
        wrap_cnt      = 0;
        wraps_at_stop = -1;
        idx_at_switch = cur_idx;
        max_idx       = cur_idx;
      end else begin
        if (cur_idx == 0 && prev_idx != 0) begin
          wrap_cnt++;
        end
        if (cur_idx > max_idx) begin
          max_idx = cur_idx;
        end
      end
      if (stop && !prev_stop) begin
        wraps_at_stop = wrap_cnt;
      end
      prev_idx  = cur_idx;
      prev_stop = stop;
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge CLK);
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hf;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge CLK);
    while (!awready) @(negedge CLK);
    check_value("wready", wready, 1);
    @(negedge CLK);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge CLK);
    check_value("bresp", bresp, 2'b00);
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
    @(negedge CLK);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge CLK);
    while (!arready) @(negedge CLK);
    @(negedge CLK);
    arvalid = 1'b0;
    while (!rvalid) @(negedge CLK);
    data = rdata;
    check_value("rresp", rresp, 2'b00);
  endtask

  task automatic write_read_back(input logic [7:0] addr, input logic [31:0] data,
                                 input logic [31:0] mask);
    logic [31:0] got;
    axi_write(addr, data);
    axi_read(addr, got);
    check_value($sformatf("rdata at 0x%02h", addr), got, data & mask);
  endtask

  // responses stay up while ready is held low
  task automatic check_backpressure();
    logic [31:0] got;
    bready = 1'b0;
    axi_write(reg_rep0, 32'h0000_0077);
    repeat (3) begin
      @(negedge CLK);
      check_value("bvalid", bvalid, 1);
    end
    bready = 1'b1;
    @(negedge CLK);
    check_value("bvalid", bvalid, 0);
    rready = 1'b0;
    axi_read(reg_rep0, got);
    repeat (3) begin
      @(negedge CLK);
      check_value("rvalid", rvalid, 1);
      check_value("rdata", rdata, 32'h0000_0077);
    end
    rready = 1'b1;
    @(negedge CLK);
    check_value("rvalid", rvalid, 0);
  endtask

  task automatic fill_row(input int i, input logic [7:0] mode, input logic req_seg,
                          input logic [31:0] rep0, input logic [31:0] rep1,
                          input longint value, input bit rel, input logic [3:0] gpio,
                          input bit steady, input logic [2:0] exp_status);
    rows[i] = '{mode, req_seg, rep0, rep1, cyc0, cyc1, value, rel, gpio, steady,
                exp_status};
  endtask

  initial begin
    #(watchdog_ns);
    $display("timeout: the test did not complete within %0d ns", watchdog_ns);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    logic [63:0] val;
    logic [15:0] cyc;
    logic [31:0] rep;
    logic        last_seg;
    int          polls;
    errors  = 0;
    reset   = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b1;
    gpio_in = '0;
    void'($urandom(32'hfc05));
    cyc0 = 16'(3 + ($urandom % 6));
    cyc1 = 16'(3 + ($urandom % 6));

    // status bits are {miss, stop, segment}
    fill_row(0, transition_mode_sync_idx, 1'b1, rep_infinite, rep_infinite, 0, 0, 4'h0, 0, 3'b001);
    fill_row(1, transition_mode_sync_idx, 1'b0, 32'd2, rep_infinite, 0, 0, 4'h0, 0, 3'b010);
    fill_row(2, transition_mode_sys_time, 1'b1, 32'd2, 32'd1, 200, 1, 4'h0, 0, 3'b011);
    fill_row(3, transition_mode_sys_time, 1'b0, 32'd1, 32'd1, -40, 1, 4'h0, 0, 3'b111);
    fill_row(4, transition_mode_sync_idx, 1'b1, 32'd1, 32'd1, 0, 0, 4'h0, 0, 3'b001);
    fill_row(5, transition_mode_gpio, 1'b0, 32'd1, rep_infinite, 2, 0, 4'hb, 1, 3'b001);
    fill_row(6, transition_mode_gpio, 1'b0, 32'd1, rep_infinite, 2, 0, 4'h4, 0, 3'b010);
    fill_row(7, transition_mode_sync_idx, 1'b0, 32'd1, rep_infinite, 0, 0, 4'h0, 0, 3'b000);

    repeat (4) @(negedge CLK);
    reset = 1'b0;

    // ----------------------------------------------------------
    // register access
    // ----------------------------------------------------------
    axi_read(reg_status, rd);
    check_value("reg_status", rd, 0);
    write_read_back(reg_ctrl, 32'h0000_0002, 32'h0000_0002);
    write_read_back(reg_mode, 32'hffff_ff5a, 32'h0000_00ff);
    write_read_back(reg_value_lo, 32'h1234_5678, '1);
    write_read_back(reg_value_hi, 32'h9abc_def0, '1);
    write_read_back(reg_cycle0, {16'hbeef, cyc0}, 32'h0000_ffff);
    write_read_back(reg_cycle1, {16'hcafe, cyc1}, 32'h0000_ffff);
    write_read_back(reg_rep0, 32'hdead_beef, '1);
    write_read_back(reg_rep1, 32'h0bad_f00d, '1);
    check_backpressure();
    write_read_back(8'h3c, '1, '0);

    // ----------------------------------------------------------
    // transition table
    // ----------------------------------------------------------
    last_seg = 1'b0;
    for (int r = 0; r < num_rows; r++) begin
      val = rows[r].rel ? tb_time + 64'(rows[r].value) : 64'(rows[r].value);
      axi_write(reg_mode, {24'h0, rows[r].mode});
      axi_write(reg_value_lo, val[31:0]);
      axi_write(reg_value_hi, val[63:32]);
      axi_write(reg_cycle0, {16'h0, rows[r].cycle0});
      axi_write(reg_cycle1, {16'h0, rows[r].cycle1});
      axi_write(reg_rep0, rows[r].rep0);
      axi_write(reg_rep1, rows[r].rep1);
      axi_write(reg_ctrl, {30'h0, rows[r].req_seg, 1'b1});
      @(negedge CLK);
      gpio_in = rows[r].gpio;
      if (rows[r].steady) begin
        for (int p = 0; p < steady_polls; p++) begin
          axi_read(reg_status, rd);
          check_value("reg_status", rd, {29'h0, rows[r].exp_status});
        end
      end else begin
        polls = 0;
        do begin
          axi_read(reg_status, rd);
          polls++;
        end while (rd[2:0] !== rows[r].exp_status && polls < poll_limit);
        check_value("reg_status", rd, {29'h0, rows[r].exp_status});
      end
      // the status pins follow the same state as the register
      check_value("segment", segment, rows[r].exp_status[0]);
      check_value("stop", stop, rows[r].exp_status[1]);
      check_value("err_miss", err_miss, rows[r].exp_status[2]);
      // a switch restarts the loop count of the new segment
      if (rows[r].exp_status[0] != last_seg) begin
        cyc = rows[r].exp_status[0] ? rows[r].cycle1 : rows[r].cycle0;
        rep = rows[r].exp_status[0] ? rows[r].rep1 : rows[r].rep0;
        check_value("idx within cycle", max_idx <= cyc, 1);
        if (rows[r].exp_status[1]) begin
          check_value("wraps until stop", 64'(wraps_at_stop), 64'(rep) + 1);
        end
        if (rows[r].mode == transition_mode_gpio) begin
          check_value("idx at switch", idx_at_switch, 0);
        end
      end
      last_seg = rows[r].exp_status[0];
    end

    $display("checks done, %0d error(s)", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
source/stm_pkg.sv
source/stm_settings_if.sv
source/stm_axil_regs.sv
source/stm_timebase.sv
source/stm_swapchain.sv
source/stm_top.sv
tests/stm_props.sv
tests/tb_stm_top.sv

// File: Bender.yml
package:
  name: stm_swapchain

sources:
  - source/stm_pkg.sv
  - source/stm_settings_if.sv
  - source/stm_axil_regs.sv
  - source/stm_timebase.sv
  - source/stm_swapchain.sv
  - source/stm_top.sv
  - target: test
    files:
      - tests/stm_props.sv
      - tests/tb_stm_top.sv
